// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_data_memory
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: FAIL, run did not complete"; exit 1; fi
	@echo "Result: PASS"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/access_check.sv
// Purely combinational and err is reported whether or not a strobe is high
`timescale 1ns/100ps
`default_nettype none

module access_check import mem_pkg::*; (
    input  logic                  rst,
    input  logic                  rd,
    input  logic                  wr,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  mem_size_e             size,
    output logic                  err,
    output logic                  acc_rd,
    output logic                  acc_wr
);

    logic out_of_range;
    logic misaligned;

    // Anything past the last byte of the banks
    assign out_of_range = (addr >= ADDR_WIDTH'(MEM_BYTES));

    // Alignment per access size
    always_comb begin
        case (size)
            BYTE:    misaligned = 1'b0;
            HALF:    misaligned = addr[0];
            WORD:    misaligned = (addr[1:0] != 2'b00);
            // Unused size code
            default: misaligned = 1'b1;
        endcase
    end

    assign err = out_of_range | misaligned;

    // Gated strobes for the rest of the design
    // Read has priority, a colliding write is dropped
    assign acc_rd = rd & ~err & ~rst;
    assign acc_wr = wr & ~rd & ~err & ~rst;

endmodule

`default_nettype wire

// File: hdl/byte_bank.sv
// Contents are not cleared by reset and only the read register resets, with read winning over write
`timescale 1ns/100ps
`default_nettype none

module byte_bank import mem_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rd,
    input  logic                       we,
    input  logic [BANK_ADDR_WIDTH-1:0] addr,
    input  logic [7:0]                 din,
    output logic [7:0]                 dout
);

    // Storage array, inferred as block RAM
    (* ram_style = "block" *)
    logic [7:0] mem [0:(1 << BANK_ADDR_WIDTH)-1];

    // Registered read port, holds between reads
    always_ff @(posedge clk) begin
        if (rst) begin
            dout <= '0;
        end else if (rd) begin
            dout <= mem[addr];
        end
    end

    // Write port, suppressed by a read in the same cycle
    always_ff @(posedge clk) begin
        if (we && !rd) begin
            mem[addr] <= din;
        end
    end

endmodule

`default_nettype wire

// File: hdl/data_memory.sv
// One access per cycle with loads returning one cycle later and no handshake beyond rd and wr
`timescale 1ns/100ps
`default_nettype none

module data_memory import mem_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd,
    input  logic                  wr,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] din,
    input  mem_size_e             size,
    input  mem_sign_e             sign,
    output logic [DATA_WIDTH-1:0] dout,
    output logic                  err
);

    // Gated strobes from the checker
    logic                       acc_rd;
    logic                       acc_wr;

    // Store path into the banks
    logic [DATA_WIDTH-1:0]      lane_din;
    logic [LANES-1:0]           lane_we;

    // Word index shared by all banks
    logic [BANK_ADDR_WIDTH-1:0] bank_addr;

    // Concatenated bank outputs, lane 0 in the low byte
    logic [DATA_WIDTH-1:0]      raw_dout;

    assign bank_addr = addr[BANK_ADDR_WIDTH+1:2];

    //////////////////////////////////////////////////////////////////////
    // Range and alignment check
    //////////////////////////////////////////////////////////////////////

    access_check u_check (
        .rst    (rst),
        .rd     (rd),
        .wr     (wr),
        .addr   (addr),
        .size   (size),
        .err    (err),
        .acc_rd (acc_rd),
        .acc_wr (acc_wr)
    );

    // Store lanes
    store_align u_store (
        .wr       (acc_wr),
        .offset   (addr[1:0]),
        .size     (size),
        .din      (din),
        .lane_din (lane_din),
        .lane_we  (lane_we)
    );

    //////////////////////////////////////////////////////////////////////
    // Byte banks
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < LANES; i++) begin : g_bank
        byte_bank u_bank (
            .clk  (clk),
            .rst  (rst),
            .rd   (acc_rd),
            .we   (lane_we[i]),
            .addr (bank_addr),
            .din  (lane_din[8*i +: 8]),
            .dout (raw_dout[8*i +: 8])
        );
    end

    // Load result, one cycle after the read
    load_align u_load (
        .clk    (clk),
        .rst    (rst),
        .rd     (acc_rd),
        .offset (addr[1:0]),
        .size   (size),
        .sign   (sign),
        .raw    (raw_dout),
        .dout   (dout)
    );

endmodule

`default_nettype wire

// File: hdl/load_align.sv
// Control is registered on each accepted read so dout holds until the next accepted read
`timescale 1ns/100ps
`default_nettype none

module load_align import mem_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd,
    input  logic [1:0]            offset,
    input  mem_size_e             size,
    input  mem_sign_e             sign,
    input  logic [DATA_WIDTH-1:0] raw,
    output logic [DATA_WIDTH-1:0] dout
);

    // Access attributes, aligned with the bank output register
    logic [1:0]            off_q;
    mem_size_e             size_q;
    mem_sign_e             sign_q;

    // Raw word moved down so the addressed byte sits at bit 0
    logic [DATA_WIDTH-1:0] shifted;
    logic [7:0]            sel_byte;
    logic [15:0]           sel_half;

    //////////////////////////////////////////////////////////////////////
    // Control capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            off_q  <= 2'b00;
            size_q <= BYTE;
            sign_q <= SIGNED;
        end else if (rd) begin
            off_q  <= offset;
            size_q <= size;
            sign_q <= sign;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Select and extend
    //////////////////////////////////////////////////////////////////////

    // Offset times eight
    assign shifted  = raw >> {off_q, 3'b000};
    assign sel_byte = shifted[7:0];
    assign sel_half = shifted[15:0];

    always_comb begin
        case (size_q)
            BYTE: begin
                if (sign_q == SIGNED) begin
                    dout = {{(DATA_WIDTH-8){sel_byte[7]}}, sel_byte};
                end else begin
                    dout = {{(DATA_WIDTH-8){1'b0}}, sel_byte};
                end
            end
            HALF: begin
                if (sign_q == SIGNED) begin
                    dout = {{(DATA_WIDTH-16){sel_half[15]}}, sel_half};
                end else begin
                    dout = {{(DATA_WIDTH-16){1'b0}}, sel_half};
                end
            end
            // Whole word, lane 0 least significant
            default: dout = raw;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mem_pkg.sv
// Geometry fixed at 16 KiB in four byte banks behind a 16-bit byte address and no sizes are overridable
`default_nettype none

package mem_pkg;

    //////////////////////////////////////////////////////////////////////
    // Memory geometry
    //////////////////////////////////////////////////////////////////////

    // Byte address port width, wider than needed so range check matters
    localparam int ADDR_WIDTH      = 16;
    // Capacity in bytes
    localparam int MEM_BYTES       = 16384;
    // Word index into each bank, address bits 13..2
    localparam int BANK_ADDR_WIDTH = 12;
    localparam int DATA_WIDTH      = 32;
    // One bank per byte lane
    localparam int LANES           = 4;

    //////////////////////////////////////////////////////////////////////
    // Access encodings
    //////////////////////////////////////////////////////////////////////

    // Size code 3 is unused and rejected as an error
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_e;

    // Load extension mode
    typedef enum logic {
        SIGNED   = 1'b0,
        UNSIGNED = 1'b1
    } mem_sign_e;

endpackage

`default_nettype wire

// File: hdl/store_align.sv
// Assumes offset is already aligned for size and misaligned stores are blocked upstream
`timescale 1ns/100ps
`default_nettype none

module store_align import mem_pkg::*; (
    input  logic                  wr,
    input  logic [1:0]            offset,
    input  mem_size_e             size,
    input  logic [DATA_WIDTH-1:0] din,
    output logic [DATA_WIDTH-1:0] lane_din,
    output logic [LANES-1:0]      lane_we
);

    // Byte enables before shifting to the offset
    logic [LANES-1:0] base_mask;

    //////////////////////////////////////////////////////////////////////
    // Lane data
    //////////////////////////////////////////////////////////////////////

    // Replicate the low part across lanes
    // Whichever lanes are enabled then see the right bytes
    always_comb begin
        case (size)
            BYTE:    lane_din = {4{din[7:0]}};
            HALF:    lane_din = {2{din[15:0]}};
            default: lane_din = din;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Lane enables
    //////////////////////////////////////////////////////////////////////

    // One, two or four lanes
    always_comb begin
        case (size)
            BYTE:    base_mask = 4'b0001;
            HALF:    base_mask = 4'b0011;
            WORD:    base_mask = 4'b1111;
            default: base_mask = 4'b0000;
        endcase
    end

    // Move to the addressed lane
    // No enables at all without an accepted store
    always_comb begin
        if (wr) begin
            lane_we = base_mask << offset;
        end else begin
            lane_we = '0;
        end
    end

endmodule

`default_nettype wire

// File: tb.f
hdl/mem_pkg.sv
hdl/byte_bank.sv
hdl/access_check.sv
hdl/store_align.sv
hdl/load_align.sv
hdl/data_memory.sv
test/data_memory_props.sv
test/tb_data_memory.sv

// File: test/data_memory_props.sv
// Covers only strobe gating and dout hold, data values are checked by the testbench model
`timescale 1ns/100ps
`default_nettype none

module data_memory_props import mem_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  err,
    input logic                  acc_rd,
    input logic                  acc_wr,
    input logic [LANES-1:0]      lane_we,
    input logic [DATA_WIDTH-1:0] dout
);

    // A rejected access never reaches the banks
    a_err_blocks_strobes: assert property (@(posedge clk) err |-> (!acc_rd && !acc_wr))
        else $error("read or write strobe active while err is high");

    // No lane enable without an accepted store
    a_lane_we_gated: assert property (@(posedge clk) !acc_wr |-> (lane_we == '0))
        else $error("lane write enable active without an accepted store");

    // Load result holds until the next accepted read
    a_dout_hold: assert property (@(posedge clk) disable iff (rst) !acc_rd |=> $stable(dout))
        else $error("dout changed without an accepted read");

endmodule

bind data_memory data_memory_props u_props (
    .clk     (clk),
    .rst     (rst),
    .err     (err),
    .acc_rd  (acc_rd),
    .acc_wr  (acc_wr),
    .lane_we (lane_we),
    .dout    (dout)
);

`default_nettype wire

// File: test/tb_data_memory.sv
// Random accesses stay in a 256-byte window at 0x0200 written first, since banks power up unknown
`timescale 1ns/100ps
`default_nettype none

module tb_data_memory import mem_pkg::*; ();

    localparam int          TIMEOUT_CYCLES  = 2000;
    localparam int          RANDOM_ACCESSES = 1000;
    localparam logic [15:0] SEED            = 16'd66;
    localparam logic [15:0] WINDOW          = 16'h0200;

    logic                  clk;
    logic                  rst;
    logic                  rd;
    logic                  wr;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] din;
    logic [DATA_WIDTH-1:0] dout;
    mem_size_e             size;
    mem_sign_e             sign;
    logic                  err;

    // Byte-array reference model
    logic [7:0]  model [0:MEM_BYTES-1];
    logic [15:0] lfsr;
    logic [31:0] exp_dout;
    logic        exp_e;
    int          errors;
    int          test_start;
    int          tests_passed;
    int          tests_failed;
    int          cycles;

    data_memory UUT (
        .clk  (clk),
        .rst  (rst),
        .rd   (rd),
        .wr   (wr),
        .addr (addr),
        .din  (din),
        .size (size),
        .sign (sign),
        .dout (dout),
        .err  (err)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference rules and random source
    //////////////////////////////////////////////////////////////////////

    // Galois form, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic ref_err(input logic [15:0] a, input logic [1:0] s);
        return (a >= 16'(MEM_BYTES)) || (s == 2'd3) || (s == 2'd1 && a[0])
            || (s == 2'd2 && a[1:0] != 2'b00);
    endfunction

    // Right-justified, sign 0 extends the top bit
    function automatic logic [31:0] ref_load(input logic [15:0] a, input logic [1:0] s,
                                             input logic sg);
        logic [13:0] i;
        logic [15:0] h;
        i = a[13:0];
        h = {model[i + 14'd1], model[i]};
        case (s)
            2'd0:    return sg ? {24'h0, model[i]} : {{24{model[i][7]}}, model[i]};
            2'd1:    return sg ? {16'h0, h} : {{16{h[15]}}, h};
            default: return {model[i + 14'd3], model[i + 14'd2], h};
        endcase
    endfunction

    task automatic ref_store(input logic [15:0] a, input logic [1:0] s, input logic [31:0] d);
        logic [13:0] i;
        i = a[13:0];
        model[i] = d[7:0];
        if (s != 2'd0) model[i + 14'd1] = d[15:8];
        if (s == 2'd2) begin
            model[i + 14'd2] = d[23:16];
            model[i + 14'd3] = d[31:24];
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Drive helpers, one call per cycle
    //////////////////////////////////////////////////////////////////////

    task automatic access(input logic r, input logic w, input logic [15:0] a,
                          input logic [1:0] s, input logic sg, input logic [31:0] d);
        @(posedge clk);
        #1;
        rd   = r;
        wr   = w;
        addr = a;
        size = mem_size_e'(s);
        sign = mem_sign_e'(sg);
        din  = d;
    endtask

    task automatic write_mem(input logic [15:0] a, input logic [1:0] s, input logic [31:0] d);
        access(1'b0, 1'b1, a, s, 1'b0, d);
    endtask

    task automatic read_mem(input logic [15:0] a, input logic [1:0] s, input logic sg);
        access(1'b1, 1'b0, a, s, sg, 32'h0);
    endtask

    task automatic idle_cycle();
        access(1'b0, 1'b0, 16'h0000, 2'd0, 1'b0, 32'h0);
    endtask

    task automatic random_access();
        logic        is_rd;
        logic [7:0]  off;
        logic [15:0] a;
        is_rd = 1'(take_bits(1));
        off   = 8'(take_bits(8));
        // Align half the time so most accesses are accepted
        if (1'(take_bits(1))) off[1:0] = 2'b00;
        a = WINDOW + {8'h00, off};
        if (4'(take_bits(4)) == 4'h0) a = 16'(take_bits(16)) | 16'h4000;
        access(is_rd, !is_rd, a, 2'(take_bits(2)), 1'(take_bits(1)), take_bits(32));
    endtask

    // Two idle cycles let the last read reach its check
    task automatic end_test(input int num, input string name);
        idle_cycle();
        idle_cycle();
        if (errors == test_start) tests_passed++;
        else tests_failed++;
        $display("Test %0d %s: %s, %0d errors", num, name,
                 (errors == test_start) ? "ok" : "FAILED", errors - test_start);
        test_start = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks at the falling edge, where inputs and dout are settled
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            exp_dout = '0;
        end else begin
            exp_e = ref_err(addr, size);
            assert (err === exp_e) else begin
                $display("MISMATCH err: expected %h, got %h (addr %h)", exp_e, err, addr);
                errors++;
            end
            assert (dout === exp_dout) else begin
                $display("MISMATCH dout: expected %h, got %h", exp_dout, dout);
                errors++;
            end
            // Inputs seen here are sampled at the next rising edge
            if (rd && !exp_e) exp_dout = ref_load(addr, size, sign);
            else if (wr && !exp_e) ref_store(addr, size, din);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [15:0] a;
        clk = 1'b0;
        rst = 1'b1;
        rd = 1'b0;
        wr = 1'b0;
        addr = '0;
        din = '0;
        size = BYTE;
        sign = SIGNED;
        lfsr = SEED;
        errors = 0;
        test_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycles = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle after reset, then aligned words including the last one
        idle_cycle();
        for (int k = 0; k < 4; k++) write_mem(16'h3FFC - 16'(k) * 16'h0FFC, 2'd2, take_bits(32));
        for (int k = 0; k < 4; k++) read_mem(16'h3FFC - 16'(k) * 16'h0FFC, 2'd2, 1'b0);
        end_test(1, "word store and load");

        // Partial stores merged into a known word
        for (int k = 0; k < 4; k++) begin
            a = 16'h0040 + 16'(4 * k);
            write_mem(a, 2'd2, 32'h1122_3344);
            write_mem(a + 16'(k), 2'd0, 32'hFFFF_FFA5);
            read_mem(a, 2'd2, 1'b0);
        end
        for (int k = 0; k < 2; k++) begin
            a = 16'h0060 + 16'(4 * k);
            write_mem(a, 2'd2, 32'h5566_7788);
            write_mem(a + 16'(2 * k), 2'd1, 32'hDEAD_BEEF);
            read_mem(a, 2'd2, 1'b0);
        end
        end_test(2, "byte and half lanes");

        // One word with every top bit set, one with every top bit clear
        write_mem(16'h0080, 2'd2, 32'h80F7_9AC5);
        write_mem(16'h0084, 2'd2, 32'h7F08_3A15);
        for (int w = 0; w < 2; w++) begin
            for (int k = 0; k < 4; k++) begin
                for (int s = 0; s < 2; s++) begin
                    a = 16'h0080 + 16'(4 * w + k);
                    read_mem(a, 2'd0, 1'(s));
                    if ((k % 2) == 0) read_mem(a, 2'd1, 1'(s));
                end
            end
        end
        end_test(3, "load extension");

        // Rejected reads hold dout, rejected stores leave memory alone
        // Held word differs from every rejected read target
        read_mem(16'h0084, 2'd2, 1'b0);
        read_mem(16'h0041, 2'd1, 1'b0);
        read_mem(16'h0042, 2'd2, 1'b0);
        read_mem(16'h0040, 2'd3, 1'b0);
        read_mem(16'h4040, 2'd2, 1'b0);
        access(1'b0, 1'b0, 16'h8000, 2'd0, 1'b0, 32'h0);
        write_mem(16'h0043, 2'd1, 32'hFFFF_FFFF);
        write_mem(16'h0041, 2'd2, 32'hFFFF_FFFF);
        write_mem(16'h0040, 2'd3, 32'hFFFF_FFFF);
        // Same bank index as 0x0040
        write_mem(16'h4040, 2'd2, 32'hFFFF_FFFF);
        write_mem(16'hC041, 2'd0, 32'hFFFF_FFFF);
        read_mem(16'h0040, 2'd2, 1'b0);
        end_test(4, "error rejection");

        // Read wins a collision, then back-to-back reads
        access(1'b1, 1'b1, 16'h0080, 2'd2, 1'b0, 32'h0BAD_F00D);
        read_mem(16'h0080, 2'd2, 1'b0);
        write_mem(16'h0088, 2'd2, 32'hCAFE_0001);
        read_mem(16'h0088, 2'd2, 1'b0);
        for (int k = 0; k < 4; k++) read_mem(16'h0040 + 16'(4 * k), 2'd2, 1'b0);
        read_mem(16'h0085, 2'd0, 1'b0);
        read_mem(16'h0082, 2'd1, 1'b1);
        end_test(5, "read priority and back-to-back");

        for (int k = 0; k < 64; k++) write_mem(WINDOW + 16'(4 * k), 2'd2, take_bits(32));
        for (int k = 0; k < RANDOM_ACCESSES; k++) random_access();
        end_test(6, "random loads and stores");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
